//--- tb.f
common/recip_pkg.sv
recip_table/recip_table_rom.sv
recip_table/table_arbiter.sv
design/lane_fifo.sv
design/recip_lane.sv
design/recip_unit_top.sv
verification/recip_checker.sv
verification/tb_top.sv

//--- verification/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import recip_pkg::*;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 10;
	localparam int item_budget  = 40;
	localparam int drain_limit  = 200;
	localparam int n_powers     = 16;
	localparam int n_random     = 150;
	localparam int n_burst      = 80;
	localparam int total_items  = n_powers + 2 * table_size + 4 * n_random + 2 * n_burst;

	logic        clk;
	logic        rst_n;
	logic [31:0] a_float;
	logic        a_valid;
	logic        a_ready;
	logic [31:0] a_result;
	logic        a_result_valid;
	logic        a_result_ready;
	logic [31:0] b_float;
	logic        b_valid;
	logic        b_ready;
	logic [31:0] b_result;
	logic        b_result_valid;
	logic        b_result_ready;
	logic [2:0]  test_id;
	logic        sink_random;
	int          chk_errors;
	int          pending_a;
	int          pending_b;
	int          tb_errors;
	int          stall_left_a;
	int          stall_left_b;

	recip_unit_top dut (
		.clk (clk), .rst_n (rst_n),
		.a_float (a_float), .a_valid (a_valid), .a_ready (a_ready),
		.a_result (a_result), .a_result_valid (a_result_valid),
		.a_result_ready (a_result_ready),
		.b_float (b_float), .b_valid (b_valid), .b_ready (b_ready),
		.b_result (b_result), .b_result_valid (b_result_valid),
		.b_result_ready (b_result_ready)
	);

	recip_checker chk (
		.clk (clk), .rst_n (rst_n), .test_id (test_id),
		.a_float (a_float), .a_valid (a_valid), .a_ready (a_ready),
		.a_result (a_result), .a_result_valid (a_result_valid),
		.a_result_ready (a_result_ready),
		.b_float (b_float), .b_valid (b_valid), .b_ready (b_ready),
		.b_result (b_result), .b_result_valid (b_result_valid),
		.b_result_ready (b_result_ready),
		.error_count (chk_errors), .pending_a (pending_a), .pending_b (pending_b)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// exponent kept so that 253 - e + 1 stays a normal exponent
	function automatic logic [31:0] rand_float();
		float_word_t w;

		w.f.sign = 1'($urandom % 2);
		w.f.exp  = 8'(1 + $urandom % 252);
		w.f.frac = 23'($urandom);
		return w.bits;
	endfunction

	// mostly ready, with an occasional long stall
	function automatic logic sink_choice(inout int stall_left);
		int r;

		if (!sink_random) return 1'b1;
		if (stall_left > 0) begin
			stall_left--;
			return 1'b0;
		end
		r = $urandom % 32;
		if (r == 0) begin
			stall_left = 8 + $urandom % 24;
			return 1'b0;
		end
		return r >= 10;
	endfunction

	// --------------------------------------------------
	// source and sink handshakes
	// --------------------------------------------------
	task automatic send_a(input logic [31:0] x);
		logic r;

		a_float = x;
		a_valid = 1'b1;
		do begin
			@(negedge clk) r = a_ready;
			@(posedge clk);
			#1;
		end while (!r);
		a_valid = 1'b0;
	endtask

	task automatic send_b(input logic [31:0] x);
		logic r;

		b_float = x;
		b_valid = 1'b1;
		do begin
			@(negedge clk) r = b_ready;
			@(posedge clk);
			#1;
		end while (!r);
		b_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;

		n = 0;
		while ((pending_a != 0 || pending_b != 0) && n < drain_limit) begin
			@(negedge clk);
			n++;
		end
		if (pending_a != 0 || pending_b != 0) begin
			$display("results still missing after drain: lane a %0d, lane b %0d",
				pending_a, pending_b);
			tb_errors++;
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		a_result_ready = 1'b0;
		b_result_ready = 1'b0;
		stall_left_a   = 0;
		stall_left_b   = 0;
		forever begin
			@(posedge clk);
			#1;
			a_result_ready = sink_choice(stall_left_a);
			b_result_ready = sink_choice(stall_left_b);
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(16875));
		rst_n       = 1'b0;
		a_float     = '0;
		a_valid     = 1'b0;
		b_float     = '0;
		b_valid     = 1'b0;
		test_id     = 3'd0;
		sink_random = 1'b0;
		tb_errors   = 0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;

		test_id = 3'd1;
		for (int i = 0; i < n_powers; i++) begin
			send_a({1'b0 ^ i[0], 8'(1 + 16 * i), 23'd0});
		end
		wait_drain();

		// every index, low bits zero
		test_id = 3'd2;
		fork
			for (int i = 0; i < table_size; i++) send_a({1'b0, 8'(60 + i), 6'(i), 17'd0});
			for (int i = 0; i < table_size; i++) send_b({1'b1, 8'(120 + i), 6'(i), 17'd0});
		join
		wait_drain();

		test_id = 3'd3;
		fork
			for (int i = 0; i < n_random; i++) send_a(rand_float());
			for (int i = 0; i < n_random; i++) send_b(rand_float());
		join
		wait_drain();

		test_id     = 3'd4;
		sink_random = 1'b1;
		fork
			for (int i = 0; i < n_random; i++) send_a(rand_float());
			for (int i = 0; i < n_random; i++) send_b(rand_float());
		join
		wait_drain();
		sink_random = 1'b0;

		// lane b idle, then lane a idle
		test_id = 3'd5;
		for (int i = 0; i < n_burst; i++) send_a(rand_float());
		for (int i = 0; i < n_burst; i++) send_b(rand_float());
		wait_drain();

		$display("closing report: %0d checker errors, %0d other errors", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (reset_cycles + total_items * item_budget) @(posedge clk);
		$display("timeout: run did not complete within %0d cycles",
			reset_cycles + total_items * item_budget);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/recip_checker.sv
`timescale 1ns/1ps
`default_nettype none

module recip_checker (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [2:0]                        test_id,
	input  logic [recip_pkg::float_width-1:0] a_float,
	input  logic                              a_valid,
	input  logic                              a_ready,
	input  logic [recip_pkg::float_width-1:0] a_result,
	input  logic                              a_result_valid,
	input  logic                              a_result_ready,
	input  logic [recip_pkg::float_width-1:0] b_float,
	input  logic                              b_valid,
	input  logic                              b_ready,
	input  logic [recip_pkg::float_width-1:0] b_result,
	input  logic                              b_result_valid,
	input  logic                              b_result_ready,
	output int                                error_count,
	output int                                pending_a,
	output int                                pending_b
);
	import recip_pkg::*;

	// test id on top, input word below
	logic [34:0] qa [$];
	logic [34:0] qb [$];
	logic        stall_a;
	logic        stall_b;
	logic [31:0] held_a;
	logic [31:0] held_b;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "powers_of_two";
			3'd2:    return "table_boundary";
			3'd3:    return "random_both";
			3'd4:    return "back_pressure";
			3'd5:    return "bursty_swap";
			default: return "no_test";
		endcase
	endfunction

	// --------------------------------------------------
	// reference reciprocal
	// --------------------------------------------------
	function automatic logic [31:0] ref_recip(input logic [31:0] x);
		float_word_t in_w;
		float_word_t res;
		logic [47:0] num;
		logic [47:0] base;
		logic [47:0] base_q;
		logic [47:0] next_q;
		logic [47:0] diff;
		logic [39:0] prod;

		in_w.bits = x;
		// 2/base and 2/(base + 1/64), all in Q23
		num    = 48'd1 << 47;
		base   = (48'd1 << 23) + (48'(in_w.f.frac[22:17]) << 17);
		base_q = num / base;
		next_q = num / (base + (48'd1 << 17));
		diff   = base_q - next_q;
		prod   = 40'(diff[22:0]) * 40'(in_w.f.frac[16:0]);
		res.f.sign = in_w.f.sign;
		res.f.exp  = 8'd253 - in_w.f.exp + 8'(in_w.f.frac == 23'd0);
		res.f.frac = base_q[22:0] - prod[39:17];
		return res.bits;
	endfunction

	task automatic compare_out(input int lane, input logic [31:0] actual);
		logic [34:0] head;
		logic [31:0] expected;

		if ((lane == 0 && qa.size() == 0) || (lane == 1 && qb.size() == 0)) begin
			$display("lane %0s delivered a result while no input was waiting",
				lane == 0 ? "a" : "b");
			error_count++;
			return;
		end
		head     = (lane == 0) ? qa.pop_front() : qb.pop_front();
		expected = ref_recip(head[31:0]);
		if (actual !== expected) begin
			$display("ERROR %0s lane %0s input %h: expected %h, actual %h",
				test_name(head[34:32]), lane == 0 ? "a" : "b", head[31:0], expected, actual);
			error_count++;
		end
	endtask

	initial begin
		error_count = 0;
		pending_a   = 0;
		pending_b   = 0;
		stall_a     = 1'b0;
		stall_b     = 1'b0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			stall_a = 1'b0;
			stall_b = 1'b0;
		end else begin
			if (a_valid && a_ready) qa.push_back({test_id, a_float});
			if (b_valid && b_ready) qb.push_back({test_id, b_float});

			// a stalled result must stay put
			if (stall_a && (!a_result_valid || a_result !== held_a)) begin
				$display("ERROR %0s lane a stalled result: expected %h, actual %h",
					test_name(test_id), held_a, a_result);
				error_count++;
			end
			if (stall_b && (!b_result_valid || b_result !== held_b)) begin
				$display("ERROR %0s lane b stalled result: expected %h, actual %h",
					test_name(test_id), held_b, b_result);
				error_count++;
			end

			if (a_result_valid && a_result_ready) compare_out(0, a_result);
			if (b_result_valid && b_result_ready) compare_out(1, b_result);

			stall_a   = a_result_valid && !a_result_ready;
			stall_b   = b_result_valid && !b_result_ready;
			held_a    = a_result;
			held_b    = b_result;
			pending_a = qa.size();
			pending_b = qb.size();
		end
	end

endmodule

`default_nettype wire

//--- design/recip_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module recip_unit_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [recip_pkg::float_width-1:0] a_float,
	input  logic                              a_valid,
	output logic                              a_ready,
	output logic [recip_pkg::float_width-1:0] a_result,
	output logic                              a_result_valid,
	input  logic                              a_result_ready,
	input  logic [recip_pkg::float_width-1:0] b_float,
	input  logic                              b_valid,
	output logic                              b_ready,
	output logic [recip_pkg::float_width-1:0] b_result,
	output logic                              b_result_valid,
	input  logic                              b_result_ready
);
	import recip_pkg::*;

	logic                  req_a;
	logic                  req_b;
	logic                  grant_a;
	logic                  grant_b;
	logic [d_width-1:0]    index_a;
	logic [d_width-1:0]    index_b;
	logic                  rd_en;
	logic [d_width-1:0]    rd_index;
	logic [frac_width-1:0] table_frac;
	logic [grad_width-1:0] table_grad;

	recip_lane lane_a (
		.clk (clk), .rst_n (rst_n),
		.s_float (a_float), .s_valid (a_valid), .s_ready (a_ready),
		.m_float (a_result), .m_valid (a_result_valid), .m_ready (a_result_ready),
		.table_req (req_a), .table_index (index_a), .table_grant (grant_a),
		.table_frac (table_frac), .table_grad (table_grad)
	);

	recip_lane lane_b (
		.clk (clk), .rst_n (rst_n),
		.s_float (b_float), .s_valid (b_valid), .s_ready (b_ready),
		.m_float (b_result), .m_valid (b_result_valid), .m_ready (b_result_ready),
		.table_req (req_b), .table_index (index_b), .table_grant (grant_b),
		.table_frac (table_frac), .table_grad (table_grad)
	);

	// one shared table, one read per cycle
	table_arbiter u_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_a    (req_a),
		.index_a  (index_a),
		.req_b    (req_b),
		.index_b  (index_b),
		.grant_a  (grant_a),
		.grant_b  (grant_b),
		.rd_en    (rd_en),
		.rd_index (rd_index)
	);

	recip_table_rom u_rom (
		.clk       (clk),
		.rd_en     (rd_en),
		.rd_index  (rd_index),
		.base_frac (table_frac),
		.grad      (table_grad)
	);

endmodule

`default_nettype wire

//--- design/recip_lane.sv
`timescale 1ns/1ps
`default_nettype none

module recip_lane (
	input  logic                             clk,
	input  logic                             rst_n,
	input  recip_pkg::float_word_t           s_float,
	input  logic                             s_valid,
	output logic                             s_ready,
	output recip_pkg::float_word_t           m_float,
	output logic                             m_valid,
	input  logic                             m_ready,
	output logic                             table_req,
	output logic [recip_pkg::d_width-1:0]    table_index,
	input  logic                             table_grant,
	input  logic [recip_pkg::frac_width-1:0] table_frac,
	input  logic [recip_pkg::grad_width-1:0] table_grad
);
	import recip_pkg::*;

	logic accept;
	logic credit_ok;

	// hold stage
	logic                 hold_valid;
	logic [d_width-1:0]   hold_index;
	logic [k_width-1:0]   hold_k;
	logic                 hold_sign;
	logic [exp_width-1:0] hold_exp;
	logic                 hold_frac_zero;

	// stage 1, exponent
	logic                 st1_valid;
	logic                 st1_sign;
	logic [exp_width-1:0] st1_exp;
	logic [k_width-1:0]   st1_k;

	// stage 2, table data arrives
	logic                 st2_valid;
	logic                 st2_sign;
	logic [exp_width-1:0] st2_exp;
	logic [k_width-1:0]   st2_k;

	// stage 3, base and correction
	logic                  st3_valid;
	logic                  st3_sign;
	logic [exp_width-1:0]  st3_exp;
	logic [frac_width-1:0] st3_frac;
	logic [grad_width-1:0] st3_corr;

	// stage 4, result word
	logic        st4_valid;
	float_word_t st4_word;

	logic [grad_width+k_width-1:0] product;
	logic [fifo_count_width-1:0]   fifo_count;
	logic [fifo_count_width:0]     inflight;

	// --------------------------------------------------
	// input and table request
	// --------------------------------------------------
	// hold slot frees on the grant edge
	assign s_ready     = !hold_valid || table_grant;
	assign accept      = s_valid && s_ready;

	// items past the hold stage plus what waits in the fifo
	assign inflight = fifo_count + st1_valid + st2_valid + st3_valid + st4_valid;
	assign credit_ok = (inflight < lane_fifo_depth);

	assign table_req   = hold_valid && credit_ok;
	assign table_index = hold_index;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
			st1_valid  <= 1'b0;
			st2_valid  <= 1'b0;
			st3_valid  <= 1'b0;
			st4_valid  <= 1'b0;
		end else begin
			if (accept) begin
				hold_valid <= 1'b1;
			end else if (table_grant) begin
				hold_valid <= 1'b0;
			end
			st1_valid <= table_grant;
			st2_valid <= st1_valid;
			st3_valid <= st2_valid;
			st4_valid <= st3_valid;
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	assign product = table_grad * st2_k;

	always_ff @(posedge clk) begin
		if (accept) begin
			hold_index     <= s_float.f.frac[frac_width-1 -: d_width];
			hold_k         <= s_float.f.frac[k_width-1:0];
			hold_sign      <= s_float.f.sign;
			hold_exp       <= s_float.f.exp;
			hold_frac_zero <= (s_float.f.frac == '0);
		end

		// 253 - e, one more for an exact power of two
		st1_sign <= hold_sign;
		st1_exp  <= exp_width'(2 * exp_bias - 1) - hold_exp + exp_width'(hold_frac_zero);
		st1_k    <= hold_k;

		st2_sign <= st1_sign;
		st2_exp  <= st1_exp;
		st2_k    <= st1_k;

		st3_sign <= st2_sign;
		st3_exp  <= st2_exp;
		st3_frac <= table_frac;
		st3_corr <= product[grad_width+k_width-1:k_width];

		st4_word.f.sign <= st3_sign;
		st4_word.f.exp  <= st3_exp;
		st4_word.f.frac <= st3_frac - st3_corr;
	end

	// --------------------------------------------------
	// result fifo
	// --------------------------------------------------
	lane_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (st4_valid),
		.push_data (st4_word),
		.pop       (m_valid && m_ready),
		.pop_data  (m_float),
		.not_empty (m_valid),
		.count     (fifo_count)
	);

	// a stalled result holds until taken
	out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_float));

endmodule

`default_nettype wire

//--- design/lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lane_fifo (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   push,
	input  recip_pkg::float_word_t                 push_data,
	input  logic                                   pop,
	output recip_pkg::float_word_t                 pop_data,
	output logic                                   not_empty,
	output logic [recip_pkg::fifo_count_width-1:0] count
);
	import recip_pkg::*;

	float_word_t               mem [lane_fifo_depth];
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;

	function automatic logic [fifo_ptr_width-1:0] ptr_inc(input logic [fifo_ptr_width-1:0] p);
		return (p == fifo_ptr_width'(lane_fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= push_data;
	end

	// head is visible without a pop
	assign pop_data  = mem[rd_ptr];
	assign not_empty = (count != '0);

	no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> count < fifo_count_width'(lane_fifo_depth));

	no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> not_empty);

endmodule

`default_nettype wire

//--- recip_table/table_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module table_arbiter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_a,
	input  logic [recip_pkg::d_width-1:0] index_a,
	input  logic                          req_b,
	input  logic [recip_pkg::d_width-1:0] index_b,
	output logic                          grant_a,
	output logic                          grant_b,
	output logic                          rd_en,
	output logic [recip_pkg::d_width-1:0] rd_index
);

	// high when lane b wins a tie
	logic prio_b;

	assign grant_a = req_a && (!req_b || !prio_b);
	assign grant_b = req_b && (!req_a || prio_b);

	assign rd_en    = grant_a || grant_b;
	assign rd_index = grant_b ? index_b : index_a;

	// pointer flips away from whoever was just served
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_b <= 1'b0;
		end else if (grant_a) begin
			prio_b <= 1'b1;
		end else if (grant_b) begin
			prio_b <= 1'b0;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// a lane that loses a tie is served next
	no_starve_a: assert property (@(posedge clk) disable iff (!rst_n)
		req_a && !grant_a |=> grant_a);

	no_starve_b: assert property (@(posedge clk) disable iff (!rst_n)
		req_b && !grant_b |=> grant_b);

	// lanes hold request and index until served
	hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		req_a && !grant_a |=> req_a && $stable(index_a));

	hold_b: assert property (@(posedge clk) disable iff (!rst_n)
		req_b && !grant_b |=> req_b && $stable(index_b));

endmodule

`default_nettype wire

//--- recip_table/recip_table_rom.sv
`timescale 1ns/1ps
`default_nettype none

module recip_table_rom (
	input  logic                            clk,
	input  logic                            rd_en,
	input  logic [recip_pkg::d_width-1:0]   rd_index,
	output logic [recip_pkg::frac_width-1:0] base_frac,
	output logic [recip_pkg::grad_width-1:0] grad
);
	import recip_pkg::*;

	logic [frac_width+grad_width-1:0] mem [table_size];
	logic [frac_width+grad_width-1:0] rd_word;
	logic [frac_width+grad_width-1:0] out_word;

	// --------------------------------------------------
	// table fill at elaboration
	// --------------------------------------------------
	// base steps from 1.0 by 1/64, entry is 2/base in Q23
	initial begin
		logic [47:0] num;
		logic [47:0] step;
		logic [47:0] base;
		logic [47:0] next;
		logic [47:0] base_q;
		logic [47:0] next_q;
		logic [47:0] diff;

		num    = 48'd1 << (2 * frac_width + 1);
		step   = 48'd1 << (frac_width - d_width);
		base   = 48'd1 << frac_width;
		base_q = num / base;
		for (int i = 0; i < table_size; i++) begin
			next   = base + step;
			next_q = num / next;
			diff   = base_q - next_q;
			// 2/1.0 wraps to a zero fraction, exponent rule covers it
			mem[i] = {base_q[frac_width-1:0], diff[grad_width-1:0]};
			base   = next;
			base_q = next_q;
		end
	end

	// read register, then output register
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_word <= mem[rd_index];
		end
	end

	always_ff @(posedge clk) begin
		out_word <= rd_word;
	end

	assign base_frac = out_word[grad_width +: frac_width];
	assign grad      = out_word[0 +: grad_width];

endmodule

`default_nettype wire

//--- common/recip_pkg.sv
`default_nettype none

package recip_pkg;

	// --------------------------------------------------
	// binary32 format
	// --------------------------------------------------
	localparam int exp_width   = 8;
	localparam int frac_width  = 23;
	localparam int float_width = 1 + exp_width + frac_width;
	localparam int exp_bias    = 127;

	// --------------------------------------------------
	// interpolation table
	// --------------------------------------------------
	// index from the top of the fraction
	localparam int d_width    = 6;
	// interpolation bits below the index
	localparam int k_width    = frac_width - d_width;
	localparam int grad_width = frac_width;
	localparam int table_size = 1 << d_width;

	// --------------------------------------------------
	// lane sizing
	// --------------------------------------------------
	// result fifo depth, also the credit limit per lane
	localparam int lane_fifo_depth  = 8;
	localparam int fifo_ptr_width   = $clog2(lane_fifo_depth);
	localparam int fifo_count_width = $clog2(lane_fifo_depth + 1);

	// one word, read raw or as fields
	typedef union packed {
		logic [float_width-1:0] bits;
		struct packed {
			logic                  sign;
			logic [exp_width-1:0]  exp;
			logic [frac_width-1:0] frac;
		} f;
	} float_word_t;

endpackage

`default_nettype wire
